// File: tb.f
+incdir+include
hdl/bumpyPkg.sv
hdl/levelTimer.sv
hdl/bumpyFsm.sv
hdl/bumpyMover.sv
hdl/tileCollision.sv
hdl/bumpyCore.sv
tb/bumpyCoreTb.sv

// File: Bender.yml
package:
  name: bumpy_core

sources:
  - include_dirs:
      - include
    files:
      - hdl/bumpyPkg.sv
      - hdl/levelTimer.sv
      - hdl/bumpyFsm.sv
      - hdl/bumpyMover.sv
      - hdl/tileCollision.sv
      - hdl/bumpyCore.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tb/bumpyCoreTb.sv

// File: tb/bumpyCoreTb.sv
`include "bumpy_settings.svh"

module bumpyCoreTb;

	localparam int Rounds = 8;
	localparam int RoundTicks = 40;
	localparam int SafeTicks = `LEVEL_TICKS + 30;
	localparam int MapCycles = `MAP_DEPTH + 8; // map load plus reset
	localparam int TotalCycles = (Rounds * RoundTicks + SafeTicks) * 3 +
		(Rounds + 1) * MapCycles;

	logic clk = 1'b0;
	logic resetN;
	logic tick;
	logic mapWe;
	logic [7:0] mapAddr;
	bumpyPkg::tileKind mapData;
	logic [3:0] keys;
	bumpyPkg::motionState state;
	bumpyPkg::gridPos pos;
	logic die;
	logic alive;

	bumpyPkg::tileKind tiles [`MAP_DEPTH];
	bumpyPkg::motionState mState;
	int mX;
	int mY;
	int mCnt; // running ticks seen by the model timer
	int errors;
	int checks;

	bumpyCore uut (
		.clk(clk),
		.resetN(resetN),
		.tick(tick),
		.mapWe(mapWe),
		.mapAddr(mapAddr),
		.mapData(mapData),
		.keys(keys),
		.state(state),
		.pos(pos),
		.die(die),
		.alive(alive)
	);

	always #10 clk = !clk;

	function automatic bumpyPkg::tileKind tileAt(input int x, input int y);
		if (x < 0 || y < 0 || x >= `GRID_W || y >= `GRID_H)
			return bumpyPkg::tileWall; // nothing beyond the playfield
		return tiles[y * `GRID_W + x];
	endfunction

	// {left, top, right, bottom}
	function automatic logic [3:0] edgesAt(input int x, input int y);
		logic [3:0] e;
		e[3] = x == 0 || tileAt(x - 1, y) == bumpyPkg::tileWall;
		e[2] = y == 0 || tileAt(x, y - 1) == bumpyPkg::tileWall;
		e[1] = x == `GRID_W - 1 || tileAt(x + 1, y) == bumpyPkg::tileWall;
		e[0] = y == `GRID_H - 1 || tileAt(x, y + 1) != bumpyPkg::tileFree;
		return e;
	endfunction

	function automatic logic [3:0] randomKeys();
		logic [3:0] k;
		for (int i = 0; i < 4; i++)
			k[i] = $urandom_range(3) != 0; // each key down about one tick in four
		return k;
	endfunction

	task automatic stepModel(input logic [3:0] k);
		logic [3:0] e;
		bumpyPkg::tileKind below;
		logic border;
		logic step;
		logic freeBelow;
		logic deadly;
		bumpyPkg::motionState nxt;
		e = edgesAt(mX, mY);
		below = tileAt(mX, mY + 1);
		step = below == bumpyPkg::tileRegular || below == bumpyPkg::tileGate;
		freeBelow = below == bumpyPkg::tileFree;
		case (mState)
			bumpyPkg::stLeft: border = e[3];
			bumpyPkg::stRight: border = e[1];
			bumpyPkg::stUp: border = e[2];
			default: border = e[0];
		endcase
		deadly = (e[0] && border) || tileAt(mX, mY) == bumpyPkg::tileDeath;
		nxt = mState;
		if (mState == bumpyPkg::stDie) begin
			nxt = bumpyPkg::stDie;
		end else if (mCnt == `LEVEL_TICKS) begin
			nxt = bumpyPkg::stDie; // timeOver was raised after the last tick
		end else if (e[0] && below == bumpyPkg::tileGate) begin
			nxt = bumpyPkg::stUp;
		end else if (mState == bumpyPkg::stReset) begin
			if (k != 4'hF)
				nxt = bumpyPkg::stDown;
		end else if (mState == bumpyPkg::stUp) begin
			if (deadly)
				nxt = bumpyPkg::stDie;
			else if (!k[0])
				nxt = bumpyPkg::stDown;
			else if (e[2] && (border || step))
				nxt = bumpyPkg::stDown;
			else if (freeBelow && e[0] && !k[2])
				nxt = bumpyPkg::stLeft;
			else if (freeBelow && e[0] && !k[1])
				nxt = bumpyPkg::stRight;
		end else begin
			if (deadly)
				nxt = bumpyPkg::stDie;
			else if (mState == bumpyPkg::stRight && e[1] && border)
				nxt = bumpyPkg::stLeft;
			else if (mState == bumpyPkg::stLeft && e[3] && border)
				nxt = bumpyPkg::stRight;
			else if (step && e[0])
				nxt = !k[3] ? bumpyPkg::stUp : !k[2] ? bumpyPkg::stLeft :
					!k[1] ? bumpyPkg::stRight : bumpyPkg::stIdle;
		end
		case (mState) // moves use the state from before the tick
			bumpyPkg::stReset: begin
				mX = `START_X;
				mY = `START_Y;
			end
			bumpyPkg::stLeft: mX = e[3] ? mX : mX - 1;
			bumpyPkg::stRight: mX = e[1] ? mX : mX + 1;
			bumpyPkg::stUp: mY = e[2] ? mY : mY - 1;
			bumpyPkg::stDown: mY = e[0] ? mY : mY + 1;
			default: ;
		endcase
		if (mState == bumpyPkg::stReset)
			mCnt = 0;
		else if (mState != bumpyPkg::stDie && mCnt < `LEVEL_TICKS)
			mCnt++;
		mState = nxt;
	endtask

	task automatic checkOutputs();
		bumpyPkg::gridPos ePos;
		logic eDie;
		logic eAlive;
		ePos = '{x: mX[`COORD_W-1:0], y: mY[`COORD_W-1:0]};
		eDie = mState == bumpyPkg::stDie;
		eAlive = mState != bumpyPkg::stReset && mState != bumpyPkg::stDie;
		checks++;
		assert (state == mState) else begin
			errors++;
			$display("[FAIL] state: got %h expected %h", state, mState);
		end
		assert (pos == ePos) else begin
			errors++;
			$display("[FAIL] pos: got %h expected %h", pos, ePos);
		end
		assert (die == eDie) else begin
			errors++;
			$display("[FAIL] die: got %h expected %h", die, eDie);
		end
		assert (alive == eAlive) else begin
			errors++;
			$display("[FAIL] alive: got %h expected %h", alive, eAlive);
		end
	endtask

	// starts and ends on a falling edge, one tick every 3 cycles
	task automatic runTick(input logic [3:0] k);
		logic oldDie;
		logic oldAlive;
		oldDie = mState == bumpyPkg::stDie;
		oldAlive = mState != bumpyPkg::stReset && mState != bumpyPkg::stDie;
		keys = k;
		tick = 1'b1;
		stepModel(k);
		@(negedge clk);
		tick = 1'b0;
		assert (die == oldDie) else begin // die lags the state by a cycle
			errors++;
			$display("[FAIL] die: got %h expected %h", die, oldDie);
		end
		assert (alive == oldAlive) else begin
			errors++;
			$display("[FAIL] alive: got %h expected %h", alive, oldAlive);
		end
		@(negedge clk);
		checkOutputs();
		@(negedge clk);
	endtask

	task automatic applyReset();
		resetN = 1'b0;
		repeat (4) @(negedge clk);
		resetN = 1'b1;
		mState = bumpyPkg::stReset;
		mX = `START_X;
		mY = `START_Y;
		mCnt = 0;
	endtask

	task automatic loadMap(input bit safe);
		int r;
		for (int a = 0; a < `MAP_DEPTH; a++) begin
			r = $urandom_range(99);
			if (safe)
				tiles[a] = (a / `GRID_W == 8) ? bumpyPkg::tileGate : bumpyPkg::tileFree;
			else if (r < 2)
				tiles[a] = bumpyPkg::tileDeath;
			else if (r < 8)
				tiles[a] = bumpyPkg::tileWall;
			else if (r < 12)
				tiles[a] = bumpyPkg::tileGate;
			else if (r < 32)
				tiles[a] = bumpyPkg::tileRegular;
			else
				tiles[a] = bumpyPkg::tileFree;
			mapWe = 1'b1;
			mapAddr = a[7:0];
			mapData = tiles[a];
			@(negedge clk);
		end
		mapWe = 1'b0;
		@(negedge clk);
	endtask

	task automatic playRound(input bit safe, input int ticks);
		applyReset();
		loadMap(safe);
		checkOutputs();
		for (int t = 0; t < ticks; t++)
			runTick(t < 3 ? 4'hF : randomKeys()); // idle keys first
	endtask

	initial begin
		void'($urandom(29237));
		errors = 0;
		checks = 0;
		resetN = 1'b0;
		tick = 1'b0;
		mapWe = 1'b0;
		mapAddr = '0;
		mapData = bumpyPkg::tileFree;
		keys = 4'hF;
		@(negedge clk);
		for (int r = 0; r < Rounds; r++)
			playRound(1'b0, RoundTicks);
		// gate floor keeps bumpy bouncing until the level timer runs out
		playRound(1'b1, SafeTicks);
		assert (state == bumpyPkg::stDie) else begin
			errors++;
			$display("[FAIL] state: got %h expected %h", state, bumpyPkg::stDie);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

	initial begin
		#(TotalCycles * 20 + 2000);
		$display("watchdog expired, run took longer than %0d cycles", TotalCycles);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Test failed");
		$finish;
	end

endmodule

// File: hdl/bumpyCore.sv
module bumpyCore (
	input logic clk,
	input logic resetN,
	input logic tick, // frame strobe
	input logic mapWe,
	input logic [7:0] mapAddr,
	input bumpyPkg::tileKind mapData,
	input logic [3:0] keys, // active low {up, left, right, down}
	output bumpyPkg::motionState state,
	output bumpyPkg::gridPos pos,
	output logic die,
	output logic alive
);

	bumpyPkg::collisionInfo coll;
	logic timeOver;

	bumpyFsm fsm (
		.clk(clk),
		.resetN(resetN),
		.tick(tick),
		.keys(keys),
		.coll(coll),
		.timeOver(timeOver),
		.state(state),
		.die(die),
		.alive(alive)
	);

	bumpyMover mover (
		.clk(clk),
		.resetN(resetN),
		.tick(tick),
		.state(state),
		.hitEdge(coll.hitEdge),
		.pos(pos)
	);

	tileCollision collision (
		.clk(clk),
		.mapWe(mapWe),
		.mapAddr(mapAddr),
		.mapData(mapData),
		.pos(pos),
		.state(state),
		.coll(coll)
	);

	levelTimer timer (
		.clk(clk),
		.resetN(resetN),
		.tick(tick),
		.state(state),
		.timeOver(timeOver)
	);

endmodule

// File: hdl/tileCollision.sv
`include "bumpy_settings.svh"

module tileCollision (
	input logic clk,
	input logic mapWe,
	input logic [7:0] mapAddr,
	input bumpyPkg::tileKind mapData,
	input bumpyPkg::gridPos pos,
	input bumpyPkg::motionState state,
	output bumpyPkg::collisionInfo coll
);

	bumpyPkg::tileKind tileMap [`MAP_DEPTH];
	bumpyPkg::tileKind curTile;
	bumpyPkg::tileKind belowTile;
	bumpyPkg::tileKind aboveTile;
	bumpyPkg::tileKind leftTile;
	bumpyPkg::tileKind rightTile;
	logic atLeft;
	logic atTop;
	logic atRight;
	logic atBottom;
	logic [3:0] hitEdge;

	function automatic logic [7:0] cellAddr(input logic [`COORD_W-1:0] x,
			input logic [`COORD_W-1:0] y);
		return 8'(y * `GRID_W + x);
	endfunction

	always_ff @(posedge clk) begin
		if (mapWe && mapAddr < `MAP_DEPTH)
			tileMap[mapAddr] <= mapData;
	end

	assign atLeft = pos.x == 0;
	assign atTop = pos.y == 0;
	assign atRight = pos.x == `GRID_W - 1;
	assign atBottom = pos.y == `GRID_H - 1;

	// off-grid neighbours read as wall
	always_comb begin
		curTile = tileMap[cellAddr(pos.x, pos.y)];
		belowTile = atBottom ? bumpyPkg::tileWall : tileMap[cellAddr(pos.x, pos.y + 1'b1)];
		aboveTile = atTop ? bumpyPkg::tileWall : tileMap[cellAddr(pos.x, pos.y - 1'b1)];
		leftTile = atLeft ? bumpyPkg::tileWall : tileMap[cellAddr(pos.x - 1'b1, pos.y)];
		rightTile = atRight ? bumpyPkg::tileWall : tileMap[cellAddr(pos.x + 1'b1, pos.y)];
	end

	assign hitEdge[bumpyPkg::EdgeBottom] = atBottom || belowTile != bumpyPkg::tileFree;
	assign hitEdge[bumpyPkg::EdgeTop] = atTop || aboveTile == bumpyPkg::tileWall;
	assign hitEdge[bumpyPkg::EdgeLeft] = atLeft || leftTile == bumpyPkg::tileWall;
	assign hitEdge[bumpyPkg::EdgeRight] = atRight || rightTile == bumpyPkg::tileWall;

	always_comb begin
		coll.step = belowTile inside {bumpyPkg::tileRegular, bumpyPkg::tileGate};
		coll.free = belowTile == bumpyPkg::tileFree;
		coll.spike = curTile == bumpyPkg::tileDeath;
		coll.teleport = belowTile == bumpyPkg::tileGate;
		coll.hitEdge = hitEdge;
		case (state)
			bumpyPkg::stLeft: coll.border = hitEdge[bumpyPkg::EdgeLeft];
			bumpyPkg::stRight: coll.border = hitEdge[bumpyPkg::EdgeRight];
			bumpyPkg::stUp: coll.border = hitEdge[bumpyPkg::EdgeTop];
			default: coll.border = hitEdge[bumpyPkg::EdgeBottom]; // idle and falling look down
		endcase
	end

endmodule

// File: hdl/bumpyMover.sv
`include "bumpy_settings.svh"

module bumpyMover (
	input logic clk,
	input logic resetN,
	input logic tick,
	input bumpyPkg::motionState state,
	input logic [3:0] hitEdge, // {left, top, right, bottom}
	output bumpyPkg::gridPos pos
);

	localparam logic [`COORD_W-1:0] StartX = `START_X;
	localparam logic [`COORD_W-1:0] StartY = `START_Y;
	localparam bumpyPkg::gridPos SpawnPos = '{x: StartX, y: StartY};

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			pos <= SpawnPos;
		end else if (state == bumpyPkg::stReset) begin
			pos <= SpawnPos; // back to spawn between lives
		end else if (tick) begin
			case (state)
				bumpyPkg::stLeft: begin
					if (!hitEdge[bumpyPkg::EdgeLeft])
						pos.x <= pos.x - 1'b1;
				end
				bumpyPkg::stRight: begin
					if (!hitEdge[bumpyPkg::EdgeRight])
						pos.x <= pos.x + 1'b1;
				end
				bumpyPkg::stUp: begin
					if (!hitEdge[bumpyPkg::EdgeTop])
						pos.y <= pos.y - 1'b1; // row 0 is the top
				end
				bumpyPkg::stDown: begin
					if (!hitEdge[bumpyPkg::EdgeBottom])
						pos.y <= pos.y + 1'b1;
				end
				default: pos <= pos; // idle and die stay put
			endcase
		end
	end

	// edge bits from the map decoder must keep the character on the grid
	posInGrid: assert property (@(posedge clk) disable iff (!resetN)
		pos.x < `GRID_W && pos.y < `GRID_H)
		else $error("pos left the grid x=%h y=%h", pos.x, pos.y);

endmodule

// File: hdl/bumpyFsm.sv
module bumpyFsm (
	input logic clk,
	input logic resetN,
	input logic tick,
	input logic [3:0] keys, // active low {up, left, right, down}
	input bumpyPkg::collisionInfo coll,
	input logic timeOver,
	output bumpyPkg::motionState state,
	output logic die,
	output logic alive
);

	bumpyPkg::motionState nextState;
	logic upKey;
	logic leftKey;
	logic rightKey;
	logic downKey;
	logic anyKey;
	logic onFloor;
	logic deadly;

	assign upKey = !keys[3];
	assign leftKey = !keys[2];
	assign rightKey = !keys[1];
	assign downKey = !keys[0];
	assign anyKey = upKey || leftKey || rightKey || downKey;

	assign onFloor = coll.hitEdge[bumpyPkg::EdgeBottom];
	assign deadly = (onFloor && coll.border) || coll.spike; // fell out or hit a spike

	always_comb begin
		nextState = state;
		if (state == bumpyPkg::stDie) begin
			nextState = bumpyPkg::stDie; // only reset leaves die
		end else if (timeOver) begin
			nextState = bumpyPkg::stDie;
		end else if (onFloor && coll.teleport) begin
			nextState = bumpyPkg::stUp; // gate launches upward
		end else begin
			case (state)
				bumpyPkg::stReset: begin
					if (anyKey)
						nextState = bumpyPkg::stDown;
				end
				bumpyPkg::stIdle, bumpyPkg::stLeft, bumpyPkg::stRight, bumpyPkg::stDown: begin
					if (deadly) begin
						nextState = bumpyPkg::stDie;
					end else if (state == bumpyPkg::stRight &&
							coll.hitEdge[bumpyPkg::EdgeRight] && coll.border) begin
						nextState = bumpyPkg::stLeft; // bounce off right side
					end else if (state == bumpyPkg::stLeft &&
							coll.hitEdge[bumpyPkg::EdgeLeft] && coll.border) begin
						nextState = bumpyPkg::stRight;
					end else if (coll.step && onFloor) begin
						if (upKey)
							nextState = bumpyPkg::stUp;
						else if (leftKey)
							nextState = bumpyPkg::stLeft;
						else if (rightKey)
							nextState = bumpyPkg::stRight;
						else
							nextState = bumpyPkg::stIdle;
					end
				end
				bumpyPkg::stUp: begin
					if (deadly) begin
						nextState = bumpyPkg::stDie;
					end else if (downKey) begin
						nextState = bumpyPkg::stDown;
					end else if (coll.hitEdge[bumpyPkg::EdgeTop] &&
							(coll.border || coll.step)) begin
						nextState = bumpyPkg::stDown; // head hit, fall back
					end else if (coll.free && onFloor) begin
						if (leftKey)
							nextState = bumpyPkg::stLeft;
						else if (rightKey)
							nextState = bumpyPkg::stRight;
					end
				end
				default: nextState = state;
			endcase
		end
	end

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			state <= bumpyPkg::stReset;
		end else if (tick) begin
			state <= nextState;
		end
	end

	// status outputs lag the state by one cycle
	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			die <= 1'b0;
			alive <= 1'b0;
		end else begin
			die <= state == bumpyPkg::stDie;
			alive <= state != bumpyPkg::stReset && state != bumpyPkg::stDie;
		end
	end

	dieSticky: assert property (@(posedge clk) disable iff (!resetN) die |=> die)
		else $error("die dropped without reset");

	stateLegal: assert property (@(posedge clk) disable iff (!resetN)
		state inside {bumpyPkg::stReset, bumpyPkg::stIdle, bumpyPkg::stLeft,
			bumpyPkg::stRight, bumpyPkg::stDown, bumpyPkg::stUp, bumpyPkg::stDie})
		else $error("illegal motion state %h", state);

endmodule

// File: hdl/levelTimer.sv
`include "bumpy_settings.svh"

module levelTimer (
	input logic clk,
	input logic resetN,
	input logic tick,
	input bumpyPkg::motionState state,
	output logic timeOver
);

	localparam int CntW = $clog2(`LEVEL_TICKS + 1);
	localparam logic [CntW-1:0] Limit = CntW'(`LEVEL_TICKS);

	logic [CntW-1:0] tickCnt;
	logic running;

	assign running = state != bumpyPkg::stReset && state != bumpyPkg::stDie;

	always_ff @(posedge clk or negedge resetN) begin
		if (!resetN) begin
			tickCnt <= '0;
			timeOver <= 1'b0;
		end else begin
			if (state == bumpyPkg::stReset)
				tickCnt <= '0;
			else if (tick && running && tickCnt != Limit)
				tickCnt <= tickCnt + 1'b1; // saturates at the limit
			timeOver <= tickCnt == Limit;
		end
	end

endmodule

// File: hdl/bumpyPkg.sv
`include "bumpy_settings.svh"

package bumpyPkg;

	typedef enum logic [3:0] {
		stReset = 4'd0,
		stIdle = 4'd1,
		stLeft = 4'd2,
		stRight = 4'd3,
		stDown = 4'd4,
		stUp = 4'd5,
		stDie = 4'd6
	} motionState;

	typedef enum logic [2:0] {
		tileFree = 3'd0,
		tileRegular = 3'd1,
		tileGate = 3'd2, // teleport step
		tileDeath = 3'd3, // spike
		tileWall = 3'd4
	} tileKind;

	// bit positions in hitEdge {left, top, right, bottom}
	localparam int EdgeBottom = 0;
	localparam int EdgeRight = 1;
	localparam int EdgeTop = 2;
	localparam int EdgeLeft = 3;

	typedef struct packed {
		logic [`COORD_W-1:0] x;
		logic [`COORD_W-1:0] y;
	} gridPos;

	typedef struct packed {
		logic step; // regular or gate below
		logic free; // nothing below
		logic border; // blocked in direction of motion
		logic spike; // standing on death tile
		logic teleport; // gate below
		logic [3:0] hitEdge;
	} collisionInfo;

endpackage

// File: include/bumpy_settings.svh
`ifndef BUMPY_SETTINGS_SVH
`define BUMPY_SETTINGS_SVH

// playfield size in cells
`define GRID_W 16
`define GRID_H 12

// bits per coordinate
`define COORD_W 4

// one tile per cell, row major
`define MAP_DEPTH (`GRID_W * `GRID_H)

// ticks per level before time over
`define LEVEL_TICKS 200

// spawn cell
`define START_X 2
`define START_Y 1

`endif
